/* fetch_top.f */
logic/rv_isa_pkg.sv
logic/fetch_cfg_pkg.sv
logic/redirect_sel.sv
logic/pc_gen.sv
logic/inst_ram.sv
logic/imem_loader.sv
logic/fetch_hold.sv
logic/fetch_top.sv
sim/tb_clkgen.sv
sim/tb_fetch_top.sv

/* logic/fetch_cfg_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// fetch front end configuration
// instruction RAM is 2^IRAM_AW words, PC upper bits ignored
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

package fetch_cfg_pkg;

	// RAM word index width, 1024 words
	localparam int IRAM_AW = 10;

	localparam int IRAM_DEPTH = 1 << IRAM_AW;

	// word index into the instruction RAM
	typedef logic [IRAM_AW-1:0] iram_addr_t;

	// host loader handshake states
	typedef enum logic [1:0] {
		IDLE  = 2'd0,
		WRITE = 2'd1,
		ACK   = 2'd2,
		DROP  = 2'd3
	} loader_state_e;

endpackage

`default_nettype wire

/* logic/fetch_hold.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// decode side hold stage
// replays the captured word while decode stalls
// valid low until the first start
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module fetch_hold (
	input  wire                       clk,
	input  wire                       rst_n,
	input  rv_isa_pkg::word_addr_t    i_pc,
	input  rv_isa_pkg::inst_t         i_rdata,
	input  wire                       i_stall,
	input  wire                       i_redir,
	input  wire                       i_cpu_start,
	output rv_isa_pkg::word_addr_t    o_id_pc,
	output rv_isa_pkg::inst_t         o_id_inst,
	output logic                      o_id_valid
);

	logic              running;
	logic              stall_d;
	rv_isa_pkg::inst_t replay;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			running    <= 1'b0;
			stall_d    <= 1'b0;
			o_id_pc    <= rv_isa_pkg::RESET_PC;
			o_id_valid <= 1'b0;
		end else begin
			running <= running | i_cpu_start;
			stall_d <= i_stall;
			if (i_cpu_start) begin
				// word in flight belongs to the old stream
				o_id_pc    <= i_pc;
				o_id_valid <= 1'b0;
			end else if (!i_stall) begin
				o_id_pc    <= i_pc;
				o_id_valid <= running & ~i_redir;
			end
		end
	end

	// capture presented word on the first stall cycle
	always_ff @(posedge clk) begin
		if (i_stall && !stall_d) begin
			replay <= i_rdata;
		end
	end

	// RAM has moved on to the next word while stalled
	assign o_id_inst = stall_d ? replay : i_rdata;

endmodule

`default_nettype wire

/* logic/fetch_top.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// RV32I instruction fetch front end
// execute must not redirect while i_stall is high
// o_redir_cause is for debug only
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module fetch_top (
	input  wire                       clk,
	input  wire                       rst_n,
	// host loader
	input  wire                       i_ld_req,
	input  fetch_cfg_pkg::iram_addr_t i_ld_addr,
	input  rv_isa_pkg::inst_t         i_ld_data,
	output logic                      o_ld_ack,
	// execute stage controls
	input  wire                       i_trap,
	input  wire                       i_mret,
	input  wire                       i_sret,
	input  wire                       i_jump,
	input  rv_isa_pkg::word_addr_t    i_mtvec,
	input  rv_isa_pkg::word_addr_t    i_mepc,
	input  rv_isa_pkg::word_addr_t    i_sepc,
	input  rv_isa_pkg::word_addr_t    i_jump_addr,
	output logic                      o_post_jump,
	// decode stage
	output rv_isa_pkg::word_addr_t    o_id_pc,
	output rv_isa_pkg::inst_t         o_id_inst,
	output logic                      o_id_valid,
	input  wire                       i_stall,
	// start control
	input  wire                       i_cpu_start,
	input  rv_isa_pkg::word_addr_t    i_start_addr,
	// debug
	output rv_isa_pkg::redir_cause_e  o_redir_cause,
	output rv_isa_pkg::word_addr_t    o_pc
);

	logic                      redir;
	rv_isa_pkg::word_addr_t    redir_pc;
	fetch_cfg_pkg::iram_addr_t ram_raddr;
	rv_isa_pkg::inst_t         ram_rdata;
	logic                      ram_wen;
	fetch_cfg_pkg::iram_addr_t ram_waddr;
	rv_isa_pkg::inst_t         ram_wdata;

	redirect_sel u_redirect_sel (
		.clk           (clk),
		.rst_n         (rst_n),
		.i_trap        (i_trap),
		.i_mret        (i_mret),
		.i_sret        (i_sret),
		.i_jump        (i_jump),
		.i_mtvec       (i_mtvec),
		.i_mepc        (i_mepc),
		.i_sepc        (i_sepc),
		.i_jump_addr   (i_jump_addr),
		.o_redir       (redir),
		.o_redir_pc    (redir_pc),
		.o_redir_cause (o_redir_cause),
		.o_post_jump   (o_post_jump)
	);

	pc_gen u_pc_gen (
		.clk          (clk),
		.rst_n        (rst_n),
		.i_cpu_start  (i_cpu_start),
		.i_start_addr (i_start_addr),
		.i_stall      (i_stall),
		.i_redir      (redir),
		.i_redir_pc   (redir_pc),
		.o_pc         (o_pc),
		.o_ram_addr   (ram_raddr)
	);

	inst_ram u_inst_ram (
		.clk     (clk),
		.i_raddr (ram_raddr),
		.o_rdata (ram_rdata),
		.i_wen   (ram_wen),
		.i_waddr (ram_waddr),
		.i_wdata (ram_wdata)
	);

	imem_loader u_imem_loader (
		.clk       (clk),
		.rst_n     (rst_n),
		.i_ld_req  (i_ld_req),
		.i_ld_addr (i_ld_addr),
		.i_ld_data (i_ld_data),
		.o_ld_ack  (o_ld_ack),
		.o_wen     (ram_wen),
		.o_waddr   (ram_waddr),
		.o_wdata   (ram_wdata)
	);

	fetch_hold u_fetch_hold (
		.clk         (clk),
		.rst_n       (rst_n),
		.i_pc        (o_pc),
		.i_rdata     (ram_rdata),
		.i_stall     (i_stall),
		.i_redir     (redir),
		.i_cpu_start (i_cpu_start),
		.o_id_pc     (o_id_pc),
		.o_id_inst   (o_id_inst),
		.o_id_valid  (o_id_valid)
	);

endmodule

`default_nettype wire

/* logic/imem_loader.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// host loader, four phase req/ack slave
// host keeps addr and data stable while req is high
// one RAM write per request
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module imem_loader (
	input  wire                       clk,
	input  wire                       rst_n,
	input  wire                       i_ld_req,
	input  fetch_cfg_pkg::iram_addr_t i_ld_addr,
	input  rv_isa_pkg::inst_t         i_ld_data,
	output logic                      o_ld_ack,
	output logic                      o_wen,
	output fetch_cfg_pkg::iram_addr_t o_waddr,
	output rv_isa_pkg::inst_t         o_wdata
);

	fetch_cfg_pkg::loader_state_e state;
	fetch_cfg_pkg::loader_state_e state_nx;

	fetch_cfg_pkg::iram_addr_t addr_q;
	rv_isa_pkg::inst_t         data_q;

	always_comb begin
		state_nx = state;
		case (state)
			fetch_cfg_pkg::IDLE: begin
				if (i_ld_req) begin
					state_nx = fetch_cfg_pkg::WRITE;
				end
			end
			fetch_cfg_pkg::WRITE: begin
				state_nx = fetch_cfg_pkg::ACK;
			end
			fetch_cfg_pkg::ACK: begin
				// hold ack until host drops req
				if (!i_ld_req) begin
					state_nx = fetch_cfg_pkg::DROP;
				end
			end
			fetch_cfg_pkg::DROP: begin
				state_nx = fetch_cfg_pkg::IDLE;
			end
			default: begin
				state_nx = fetch_cfg_pkg::IDLE;
			end
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state    <= fetch_cfg_pkg::IDLE;
			o_ld_ack <= 1'b0;
		end else begin
			state    <= state_nx;
			o_ld_ack <= (state_nx == fetch_cfg_pkg::ACK);
		end
	end

	// request payload, taken when req is first seen
	always_ff @(posedge clk) begin
		if (state == fetch_cfg_pkg::IDLE && i_ld_req) begin
			addr_q <= i_ld_addr;
			data_q <= i_ld_data;
		end
	end

	assign o_wen   = (state == fetch_cfg_pkg::WRITE);
	assign o_waddr = addr_q;
	assign o_wdata = data_q;

endmodule

`default_nettype wire

/* logic/inst_ram.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// instruction RAM, one read and one write port
// read data one cycle after the address
// contents undefined until loaded
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module inst_ram (
	input  wire                       clk,
	input  fetch_cfg_pkg::iram_addr_t i_raddr,
	output rv_isa_pkg::inst_t         o_rdata,
	input  wire                       i_wen,
	input  fetch_cfg_pkg::iram_addr_t i_waddr,
	input  rv_isa_pkg::inst_t         i_wdata
);

	rv_isa_pkg::inst_t mem [fetch_cfg_pkg::IRAM_DEPTH];

	// host write port
	always_ff @(posedge clk) begin
		if (i_wen) begin
			mem[i_waddr] <= i_wdata;
		end
	end

	// registered read, old data on same address collision
	always_ff @(posedge clk) begin
		o_rdata <= mem[i_raddr];
	end

endmodule

`default_nettype wire

/* logic/pc_gen.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// fetch program counter
// start > stall > redirect > increment
// RAM index is the low IRAM_AW bits of the PC
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module pc_gen (
	input  wire                       clk,
	input  wire                       rst_n,
	input  wire                       i_cpu_start,
	input  rv_isa_pkg::word_addr_t    i_start_addr,
	input  wire                       i_stall,
	input  wire                       i_redir,
	input  rv_isa_pkg::word_addr_t    i_redir_pc,
	output rv_isa_pkg::word_addr_t    o_pc,
	output fetch_cfg_pkg::iram_addr_t o_ram_addr
);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			o_pc <= rv_isa_pkg::RESET_PC;
		end else if (i_cpu_start) begin
			o_pc <= i_start_addr;
		end else if (i_stall) begin
			// decode busy, refetch same word
			o_pc <= o_pc;
		end else if (i_redir) begin
			o_pc <= i_redir_pc;
		end else begin
			o_pc <= o_pc + 30'd1;
		end
	end

	// upper PC bits alias onto the RAM
	assign o_ram_addr = o_pc[fetch_cfg_pkg::IRAM_AW-1:0];

endmodule

`default_nettype wire

/* logic/redirect_sel.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// redirect select, combinational target
// trap > mret > sret > jump
// jump class ignored in the cycle after a trap
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module redirect_sel (
	input  wire                       clk,
	input  wire                       rst_n,
	input  wire                       i_trap,
	input  wire                       i_mret,
	input  wire                       i_sret,
	input  wire                       i_jump,
	input  rv_isa_pkg::word_addr_t    i_mtvec,
	input  rv_isa_pkg::word_addr_t    i_mepc,
	input  rv_isa_pkg::word_addr_t    i_sepc,
	input  rv_isa_pkg::word_addr_t    i_jump_addr,
	output logic                      o_redir,
	output rv_isa_pkg::word_addr_t    o_redir_pc,
	output rv_isa_pkg::redir_cause_e  o_redir_cause,
	output logic                      o_post_jump
);

	logic jcmd;
	logic post_trap;

	assign jcmd = i_mret | i_sret | i_jump;

	// a trap always redirects, jump class only when not shadowed
	assign o_redir = i_trap | (jcmd & ~post_trap);

	always_comb begin
		if (i_trap) begin
			o_redir_pc = i_mtvec;
		end else if (i_mret) begin
			o_redir_pc = i_mepc;
		end else if (i_sret) begin
			o_redir_pc = i_sepc;
		end else begin
			o_redir_pc = i_jump_addr;
		end
	end

	always_comb begin
		if (i_trap) begin
			o_redir_cause = rv_isa_pkg::TRAP;
		end else if (post_trap) begin
			// suppressed command reports no cause
			o_redir_cause = rv_isa_pkg::NONE;
		end else if (i_mret) begin
			o_redir_cause = rv_isa_pkg::MRET;
		end else if (i_sret) begin
			o_redir_cause = rv_isa_pkg::SRET;
		end else if (i_jump) begin
			o_redir_cause = rv_isa_pkg::JUMP;
		end else begin
			o_redir_cause = rv_isa_pkg::NONE;
		end
	end

	// trap shadow and post jump flags
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			post_trap   <= 1'b0;
			o_post_jump <= 1'b0;
		end else begin
			post_trap   <= i_trap;
			o_post_jump <= jcmd;
		end
	end

endmodule

`default_nettype wire

/* logic/rv_isa_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// RV32I fetch types
// addresses are word addresses, bits 1:0 are dropped
// only the redirect causes that fetch handles are listed
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

package rv_isa_pkg;

	// byte address bits 31:2
	typedef logic [29:0] word_addr_t;

	// raw instruction word
	typedef logic [31:0] inst_t;

	// PC after reset, before any start
	localparam word_addr_t RESET_PC = 30'd0;

	// which execute control won the redirect
	typedef enum logic [2:0] {
		NONE = 3'd0,
		TRAP = 3'd1,
		MRET = 3'd2,
		SRET = 3'd3,
		JUMP = 3'd4
	} redir_cause_e;

endpackage

`default_nettype wire

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the fetch front end testbench with Verilator
cd "$(dirname "$0")" || exit 1
LOG=sim.log
rm -f "$LOG"
verilator --binary --timing --timescale 1ns/1ps -f fetch_top.f \
	--top-module tb_fetch_top -o tb_fetch_top > "$LOG" 2>&1 \
	|| { echo "build failed, see $LOG"; exit 1; }
./obj_dir/tb_fetch_top >> "$LOG" 2>&1 || echo "simulator exited with an error"
grep -q '\*\*\* FAILED \*\*\*' "$LOG" && { echo "simulation failed, see $LOG"; exit 1; }
grep -q '\*\*\* PASSED \*\*\*' "$LOG" || { echo "no verdict in $LOG"; exit 1; }
echo "simulation passed"

/* sim/tb_clkgen.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// testbench clock, 4 ns period
// starts low, first rising edge at 2 ns
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module tb_clkgen (
	output logic o_clk
);

	localparam int HALF_NS = 2;

	initial begin
		o_clk = 1'b0;
	end

	always begin
		#(HALF_NS);
		o_clk = ~o_clk;
	end

endmodule

`default_nettype wire

/* sim/tb_fetch_top.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// fetch front end testbench acting as host, execute and decode
// every fetched PC stays inside the 64 loaded words
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module tb_fetch_top;

	localparam int NUM_WORDS      = 64;
	localparam int RUN_CYCLES     = 12;
	localparam int REDIR_CYCLES   = 6;
	localparam int STALL_CYCLES   = 40;
	localparam int TEST_CYCLES    = 8 + NUM_WORDS * 4 + 2 * RUN_CYCLES + 5 * REDIR_CYCLES
		+ STALL_CYCLES + 10;
	localparam int TIMEOUT_CYCLES = 2 * TEST_CYCLES + 200;

	wire                       clk;
	logic                      rst_n = 1'b0;
	logic                      i_ld_req = 1'b0;
	fetch_cfg_pkg::iram_addr_t i_ld_addr = '0;
	rv_isa_pkg::inst_t         i_ld_data = '0;
	logic                      i_trap = 1'b0;
	logic                      i_mret = 1'b0;
	logic                      i_sret = 1'b0;
	logic                      i_jump = 1'b0;
	logic                      i_stall = 1'b0;
	logic                      i_cpu_start = 1'b0;
	rv_isa_pkg::word_addr_t    i_mtvec = 30'd8;
	rv_isa_pkg::word_addr_t    i_mepc = 30'd30;
	rv_isa_pkg::word_addr_t    i_sepc = 30'd40;
	rv_isa_pkg::word_addr_t    i_jump_addr = 30'd20;
	rv_isa_pkg::word_addr_t    i_start_addr = '0;
	logic                      o_ld_ack;
	logic                      o_post_jump;
	logic                      o_id_valid;
	rv_isa_pkg::word_addr_t    o_id_pc;
	rv_isa_pkg::word_addr_t    o_pc;
	rv_isa_pkg::inst_t         o_id_inst;
	rv_isa_pkg::redir_cause_e  o_redir_cause;

	// reference state of fetch and decode
	rv_isa_pkg::inst_t         model_mem [fetch_cfg_pkg::IRAM_DEPTH];
	rv_isa_pkg::word_addr_t    exp_q [$];
	rv_isa_pkg::word_addr_t    exp_pc = rv_isa_pkg::RESET_PC;
	rv_isa_pkg::word_addr_t    front;
	logic                      exp_valid = 1'b0;
	logic                      exp_post_jump = 1'b0;
	logic                      shadow = 1'b0;
	logic                      running = 1'b0;
	int                        cycle_cnt = 0;

	tb_clkgen u_clkgen (.o_clk(clk));

	fetch_top DUT (.*);

	task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			$display("ERROR t=%0t %s: got %h, expected %h", $time, name, got, exp);
			$display("*** FAILED ***");
			$fatal(1, "value mismatch");
		end
	endtask

	task automatic abort_run(input string why);
		$display("%s at %0t", why, $time);
		$display("*** FAILED ***");
		$fatal(1, "run aborted");
	endtask

	task automatic next_cycle();
		@(posedge clk);
		#1;
	endtask

	// one cycle pulse of {start, trap, mret, sret, jump}
	task automatic pulse_ctrl(input logic [4:0] cmd);
		{i_cpu_start, i_trap, i_mret, i_sret, i_jump} = cmd;
		next_cycle();
		{i_cpu_start, i_trap, i_mret, i_sret, i_jump} = 5'b0;
	endtask

	// four phase write of one word
	task automatic load_word(input fetch_cfg_pkg::iram_addr_t addr,
			input rv_isa_pkg::inst_t data);
		int waited;
		i_ld_addr = addr;
		i_ld_data = data;
		i_ld_req = 1'b1;
		waited = 0;
		while (!o_ld_ack) begin
			next_cycle();
			waited++;
		end
		check_val("ack rise cycles", 32'(waited), 32'd2);
		i_ld_req = 1'b0;
		waited = 0;
		while (o_ld_ack) begin
			next_cycle();
			waited++;
		end
		check_val("ack fall cycles", 32'(waited), 32'd1);
		// loader passes through its drop state
		next_cycle();
	endtask

	function automatic logic redirect_taken(input logic in_shadow);
		return i_trap | ((i_mret | i_sret | i_jump) & ~in_shadow);
	endfunction

	// debug cause of the winning control or none
	function automatic rv_isa_pkg::redir_cause_e redirect_cause(input logic in_shadow);
		if (!redirect_taken(in_shadow)) begin
			return rv_isa_pkg::NONE;
		end
		if (i_trap) begin
			return rv_isa_pkg::TRAP;
		end
		if (i_mret) begin
			return rv_isa_pkg::MRET;
		end
		if (i_sret) begin
			return rv_isa_pkg::SRET;
		end
		return rv_isa_pkg::JUMP;
	endfunction

	// priority start over stall over redirect over increment
	function automatic rv_isa_pkg::word_addr_t next_pc(input rv_isa_pkg::word_addr_t cur,
			input logic in_shadow);
		if (i_cpu_start || i_stall) begin
			return i_cpu_start ? i_start_addr : cur;
		end
		if (!redirect_taken(in_shadow)) begin
			return cur + 30'd1;
		end
		return i_trap ? i_mtvec : i_mret ? i_mepc : i_sret ? i_sepc : i_jump_addr;
	endfunction

	// outputs and driven inputs are settled mid cycle
	always @(negedge clk) begin
		if (rst_n) begin
			check_val("o_pc", 32'(o_pc), 32'(exp_pc));
			check_val("o_id_valid", 32'(o_id_valid), 32'(exp_valid));
			check_val("o_post_jump", 32'(o_post_jump), 32'(exp_post_jump));
			check_val("o_redir_cause", 32'(o_redir_cause), 32'(redirect_cause(shadow)));
			if (o_id_valid) begin
				if (exp_q.size() == 0) begin
					abort_run("decode saw a valid pair that the model did not expect");
				end
				front = exp_q[0];
				check_val("o_id_pc", 32'(o_id_pc), 32'(front));
				check_val("o_id_inst", o_id_inst, model_mem[front[fetch_cfg_pkg::IRAM_AW-1:0]]);
				// decode takes the pair only when not stalled
				if (!i_stall) begin
					void'(exp_q.pop_front());
				end
			end
			if (i_cpu_start) begin
				exp_valid = 1'b0;
			end else if (!i_stall) begin
				exp_valid = running & ~redirect_taken(shadow);
				if (exp_valid) begin
					exp_q.push_back(exp_pc);
				end
			end
			exp_pc = next_pc(exp_pc, shadow);
			exp_post_jump = i_mret | i_sret | i_jump;
			shadow = i_trap;
			running = running | i_cpu_start;
		end
	end

	always @(posedge clk) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt == TIMEOUT_CYCLES) begin
			abort_run("timeout, the stimulus did not finish in time");
		end
	end

	initial begin
		int burst;
		burst = 0;
		void'($urandom(32'he4d1_ac55));
		repeat (8) @(posedge clk);
		#1;
		rst_n = 1'b1;
		check_val("o_ld_ack", 32'(o_ld_ack), 32'd0);
		for (int i = 0; i < NUM_WORDS; i++) begin
			model_mem[i] = $urandom;
			load_word(fetch_cfg_pkg::iram_addr_t'(i), model_mem[i]);
		end
		pulse_ctrl(5'b10000);
		repeat (RUN_CYCLES) next_cycle();
		// jump then mret then sret
		pulse_ctrl(5'b00001);
		repeat (REDIR_CYCLES) next_cycle();
		pulse_ctrl(5'b00100);
		repeat (REDIR_CYCLES) next_cycle();
		pulse_ctrl(5'b00010);
		repeat (REDIR_CYCLES) next_cycle();
		// trap beats mret and shadows the next jump
		pulse_ctrl(5'b01100);
		pulse_ctrl(5'b00001);
		repeat (REDIR_CYCLES) next_cycle();
		pulse_ctrl(5'b01001);
		repeat (REDIR_CYCLES) next_cycle();
		for (int c = 0; c < STALL_CYCLES; c++) begin
			if (burst == 0 && $urandom % 3 == 0) begin
				burst = int'($urandom % 5);
			end
			i_stall = (burst > 0);
			burst = (burst > 0) ? burst - 1 : 0;
			next_cycle();
		end
		i_stall = 1'b0;
		// restart mid run
		i_start_addr = 30'd33;
		pulse_ctrl(5'b10000);
		repeat (RUN_CYCLES) next_cycle();
		$display("*** PASSED ***");
		$finish;
	end

endmodule

`default_nettype wire
